// ==== pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and fixed addresses
    //////////////////////////////////////////////////////////////////////

    // Sixteen architectural registers
    localparam int REG_BITS = 4;

    // Word addressed fetch PC
    localparam int PC_BITS = 16;

    // PC low bits that index the predictor table
    localparam int BHT_BITS = 4;

    // Number of 2-bit counters in the table
    localparam int BHT_ENTRIES = 1 << BHT_BITS;

    typedef logic [REG_BITS-1:0] reg_addr_t;
    typedef logic [PC_BITS-1:0]  pc_t;

    // Fetch address in the intercepted cycle
    localparam pc_t INT_VECTOR = 16'h0100;

    // Counter value after reset, weakly not taken
    localparam logic [1:0] CTR_INIT = 2'b01;

    //////////////////////////////////////////////////////////////////////
    // Stage payloads
    //////////////////////////////////////////////////////////////////////

    // Decoded fields of the instruction sitting in ID
    typedef struct packed {
        logic      valid;
        reg_addr_t regsrc1;
        reg_addr_t regsrc2;
        reg_addr_t regdst;
        logic      memread;
        logic      memtoreg;
        logic      isbranch;
        logic      isjump;
        pc_t       target;
    } id_info_t;

    // ID/EX entry, decode fields plus its pc and the ID prediction
    typedef struct packed {
        id_info_t info;
        pc_t      pc;
        logic     pred;
    } ex_entry_t;

    // Outcome of the EX instruction, from the execute stage
    typedef struct packed {
        logic ifbranch;
        logic spare;
        pc_t  jr_target;
    } ex_result_t;

    // Hazard unit outputs
    typedef struct packed {
        logic stall;
        logic flush_if;
        logic flush_id;
        logic flush_ex;
        logic jr;
        logic prewrong;
        logic precorrc;
        logic isintzero;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== pipe_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     CLK,
    input  wire logic     interception_i,
    input  wire logic     hold_i,
    input  wire logic     flush_i,
    input  wire payload_t d_i,
    output payload_t      q_o
);

    //////////////////////////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////////////////////////

    payload_t stage_q;

    // Flush beats hold
    // A cleared payload reads as an invalid entry downstream
    always_ff @(posedge CLK or posedge interception_i) begin
        if (interception_i) begin
            stage_q <= '0;
        end else if (flush_i) begin
            // Bubble or wrong path squash
            stage_q <= '0;
        end else if (!hold_i) begin
            stage_q <= d_i;
        end
        // Otherwise keep the entry for another cycle
    end

    assign q_o = stage_q;

endmodule

`default_nettype wire

// ==== hazard_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
    input  wire logic                 CLK,
    input  wire logic                 interception_i,
    input  wire pipe_pkg::ex_entry_t  ex_i,
    input  wire pipe_pkg::ex_result_t ex_result_i,
    input  wire pipe_pkg::reg_addr_t  src1_i,
    input  wire pipe_pkg::reg_addr_t  src2_i,
    input  wire logic                 pred_taken_id_i,
    output pipe_pkg::ctrl_t           ctrl_o
);

    //////////////////////////////////////////////////////////////////////
    // Intercepted cycle flag
    //////////////////////////////////////////////////////////////////////

    logic intercepted_q;

    // Set while the line is high, dropped at the first edge after it falls
    always_ff @(posedge CLK or posedge interception_i) begin
        if (interception_i) begin
            intercepted_q <= 1'b1;
        end else begin
            intercepted_q <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Load-use detection
    //////////////////////////////////////////////////////////////////////

    logic ex_is_load;
    logic dst_match;
    logic stall;

    // Load in EX whose result goes to a register
    assign ex_is_load = ex_i.info.valid && ex_i.info.memread && ex_i.info.memtoreg;

    // Either ID source reads the load destination
    assign dst_match = (ex_i.info.regdst == src1_i) || (ex_i.info.regdst == src2_i);

    // Interception outranks the load-use stall
    assign stall = ex_is_load && dst_match && !intercepted_q;

    //////////////////////////////////////////////////////////////////////
    // Branch and jr judgment in EX
    //////////////////////////////////////////////////////////////////////

    logic judge_en;
    logic ex_branch;
    logic pred_match;
    logic prewrong;
    logic precorrc;
    logic jr;
    logic id_redirect;

    // Judgment waits while stalled or intercepted
    assign judge_en   = ex_i.info.valid && !stall && !intercepted_q;
    assign ex_branch  = judge_en && ex_i.info.isbranch;
    assign pred_match = (ex_i.pred == ex_result_i.ifbranch);

    // Only a real branch can be mispredicted
    assign prewrong = ex_branch && !pred_match;
    assign precorrc = ex_branch && pred_match;
    assign jr       = judge_en && ex_i.info.isjump;

    // Predicted taken branch in ID steers fetch unless held
    assign id_redirect = pred_taken_id_i && !stall && !intercepted_q;

    //////////////////////////////////////////////////////////////////////
    // Control outputs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl_o           = '0;
        ctrl_o.stall     = stall;
        // Fetched slot is on the wrong path
        ctrl_o.flush_if  = prewrong || jr || id_redirect;
        // Squash the entry entering EX, stall makes it a bubble
        ctrl_o.flush_id  = intercepted_q || prewrong || jr || stall;
        ctrl_o.flush_ex  = intercepted_q;
        ctrl_o.jr        = jr;
        ctrl_o.prewrong  = prewrong;
        ctrl_o.precorrc  = precorrc;
        ctrl_o.isintzero = intercepted_q;
    end

endmodule

`default_nettype wire

// ==== branch_predictor.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_predictor (
    input  wire logic          CLK,
    input  wire logic          interception_i,
    input  wire pipe_pkg::pc_t rd_pc_i,
    output logic               taken_o,
    input  wire logic          upd_en_i,
    input  wire pipe_pkg::pc_t upd_pc_i,
    input  wire logic          upd_taken_i
);

    //////////////////////////////////////////////////////////////////////
    // Counter table
    //////////////////////////////////////////////////////////////////////

    // One 2-bit saturating counter per low PC pattern
    logic [1:0] ctr_q [pipe_pkg::BHT_ENTRIES];

    logic [pipe_pkg::BHT_BITS-1:0] rd_idx;
    logic [pipe_pkg::BHT_BITS-1:0] upd_idx;
    logic [1:0]                    upd_ctr;

    assign rd_idx  = rd_pc_i[pipe_pkg::BHT_BITS-1:0];
    assign upd_idx = upd_pc_i[pipe_pkg::BHT_BITS-1:0];
    assign upd_ctr = ctr_q[upd_idx];

    //////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////

    // Upper counter bit set means 2 or 3, predict taken
    assign taken_o = ctr_q[rd_idx][1];

    //////////////////////////////////////////////////////////////////////
    // Update port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or posedge interception_i) begin
        if (interception_i) begin
            // All counters back to weakly not taken
            for (int i = 0; i < pipe_pkg::BHT_ENTRIES; i++) begin
                ctr_q[i] <= pipe_pkg::CTR_INIT;
            end
        end else if (upd_en_i) begin
            if (upd_taken_i) begin
                // Count up, stop at strongly taken
                if (upd_ctr != 2'b11) begin
                    ctr_q[upd_idx] <= upd_ctr + 2'd1;
                end
            end else begin
                // Count down, stop at strongly not taken
                if (upd_ctr != 2'b00) begin
                    ctr_q[upd_idx] <= upd_ctr - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== pc_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module pc_unit (
    input  wire logic                 CLK,
    input  wire logic                 interception_i,
    input  wire pipe_pkg::ctrl_t      ctrl_i,
    input  wire pipe_pkg::ex_entry_t  ex_i,
    input  wire pipe_pkg::ex_result_t ex_result_i,
    input  wire logic                 id_redirect_i,
    input  wire pipe_pkg::pc_t        id_target_i,
    output pipe_pkg::pc_t             pc_o,
    output pipe_pkg::pc_t             epc_o
);

    //////////////////////////////////////////////////////////////////////
    // Next fetch address
    //////////////////////////////////////////////////////////////////////

    pipe_pkg::pc_t pc_q;
    pipe_pkg::pc_t pc_d;
    pipe_pkg::pc_t ex_fallthru;
    pipe_pkg::pc_t ex_fix_pc;

    // Sequential successor of the branch in EX
    assign ex_fallthru = ex_i.pc + 16'd1;

    // Corrected address after a misprediction
    assign ex_fix_pc = ex_result_i.ifbranch ? ex_i.info.target : ex_fallthru;

    // Highest priority first
    always_comb begin
        if (ctrl_i.isintzero) begin
            // Intercepted cycle goes to the vector
            pc_d = pipe_pkg::INT_VECTOR;
        end else if (ctrl_i.stall) begin
            pc_d = pc_q;
        end else if (ctrl_i.prewrong) begin
            pc_d = ex_fix_pc;
        end else if (ctrl_i.jr) begin
            pc_d = ex_result_i.jr_target;
        end else if (id_redirect_i) begin
            // Follow the predicted taken branch in ID
            pc_d = id_target_i;
        end else begin
            pc_d = pc_q + 16'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Fetch PC register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or posedge interception_i) begin
        if (interception_i) begin
            pc_q <= pipe_pkg::INT_VECTOR;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

    //////////////////////////////////////////////////////////////////////
    // Exception PC
    //////////////////////////////////////////////////////////////////////

    pipe_pkg::pc_t epc_q;

    // Tracks the last valid EX instruction
    // Frozen across the intercepted cycle
    always_ff @(posedge CLK) begin
        if (ex_i.info.valid && !ctrl_i.flush_ex) begin
            epc_q <= ex_i.pc;
        end
    end

    assign epc_o = epc_q;

endmodule

`default_nettype wire

// ==== pipe_frontend_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_frontend_top (
    input  wire logic                 CLK,
    input  wire logic                 interception_i,
    input  wire pipe_pkg::id_info_t   id_info_i,
    input  wire pipe_pkg::ex_result_t ex_result_i,
    output pipe_pkg::pc_t             pc_o,
    output pipe_pkg::pc_t             epc_o,
    output pipe_pkg::ctrl_t           ctrl_o,
    output pipe_pkg::pc_t             id_pc_o,
    output pipe_pkg::pc_t             ex_pc_o
);

    //////////////////////////////////////////////////////////////////////
    // Internal nets
    //////////////////////////////////////////////////////////////////////

    pipe_pkg::pc_t       fetch_pc;
    pipe_pkg::pc_t       id_pc;
    pipe_pkg::ex_entry_t id_entry;
    pipe_pkg::ex_entry_t ex_entry;
    pipe_pkg::ctrl_t     ctrl;
    logic                bp_taken;
    logic                id_pred_taken;
    logic                bp_upd_en;

    // Valid branch in ID that the table calls taken
    assign id_pred_taken = id_info_i.valid && id_info_i.isbranch && bp_taken;

    // Train only on real branches that survive interception
    assign bp_upd_en = ex_entry.info.valid && ex_entry.info.isbranch && !ctrl.flush_ex;

    // Entry heading into EX
    assign id_entry = '{info: id_info_i, pc: id_pc, pred: bp_taken};

    //////////////////////////////////////////////////////////////////////
    // Stage registers
    //////////////////////////////////////////////////////////////////////

    // IF/ID keeps just the fetch address
    pipe_reg #(.payload_t(pipe_pkg::pc_t)) if_id_i (
        .CLK(CLK), .interception_i(interception_i),
        .hold_i(ctrl.stall), .flush_i(ctrl.flush_if),
        .d_i(fetch_pc), .q_o(id_pc)
    );

    // ID/EX never holds, a stall squashes its input instead
    pipe_reg #(.payload_t(pipe_pkg::ex_entry_t)) id_ex_i (
        .CLK(CLK), .interception_i(interception_i),
        .hold_i(1'b0), .flush_i(ctrl.flush_id),
        .d_i(id_entry), .q_o(ex_entry)
    );

    //////////////////////////////////////////////////////////////////////
    // Control blocks
    //////////////////////////////////////////////////////////////////////

    branch_predictor branch_predictor_i (
        .CLK(CLK), .interception_i(interception_i),
        .rd_pc_i(id_pc), .taken_o(bp_taken),
        .upd_en_i(bp_upd_en), .upd_pc_i(ex_entry.pc),
        .upd_taken_i(ex_result_i.ifbranch)
    );

    hazard_unit hazard_unit_i (
        .CLK(CLK), .interception_i(interception_i),
        .ex_i(ex_entry), .ex_result_i(ex_result_i),
        .src1_i(id_info_i.regsrc1), .src2_i(id_info_i.regsrc2),
        .pred_taken_id_i(id_pred_taken), .ctrl_o(ctrl)
    );

    pc_unit pc_unit_i (
        .CLK(CLK), .interception_i(interception_i),
        .ctrl_i(ctrl), .ex_i(ex_entry), .ex_result_i(ex_result_i),
        .id_redirect_i(id_pred_taken), .id_target_i(id_info_i.target),
        .pc_o(fetch_pc), .epc_o(epc_o)
    );

    // Observation ports
    assign pc_o    = fetch_pc;
    assign ctrl_o  = ctrl;
    assign id_pc_o = id_pc;
    assign ex_pc_o = ex_entry.pc;

endmodule

`default_nettype wire

// ==== tb_pipe_frontend.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_pipe_frontend;

    //////////////////////////////////////////////////////////////////////
    // DUT and stimulus nets
    //////////////////////////////////////////////////////////////////////

    logic                 CLK = 1'b0;
    logic                 interception_i;
    pipe_pkg::id_info_t   id_info_i;
    pipe_pkg::ex_result_t ex_result_i;
    pipe_pkg::pc_t        pc_o;
    pipe_pkg::pc_t        epc_o;
    pipe_pkg::ctrl_t      ctrl_o;
    pipe_pkg::pc_t        id_pc_o;
    pipe_pkg::pc_t        ex_pc_o;

    // Mirror of every state element in the front end
    typedef struct packed {
        pipe_pkg::pc_t                          pc;
        pipe_pkg::pc_t                          id_pc;
        pipe_pkg::ex_entry_t                    ex;
        logic [pipe_pkg::BHT_ENTRIES-1:0][1:0]  ctr;
        logic                                   intercepted;
        pipe_pkg::pc_t                          epc;
        logic                                   epc_known;
    } model_state_t;

    // Decoded program and EX outcomes indexed by low pc byte
    pipe_pkg::id_info_t   prog [256];
    pipe_pkg::ex_result_t outcome [256];

    model_state_t state;
    integer       seed = 95221;
    string        test_name = "reset";
    int           cycle_count = 0;
    int           n_stall = 0;
    int           n_prewrong = 0;
    int           n_precorrc = 0;
    int           n_jr = 0;
    int           n_redirect = 0;

    // 40 ns period
    always #20 CLK = ~CLK;

    pipe_frontend_top pipe_frontend_top_i (
        .CLK(CLK), .interception_i(interception_i),
        .id_info_i(id_info_i), .ex_result_i(ex_result_i),
        .pc_o(pc_o), .epc_o(epc_o), .ctrl_o(ctrl_o),
        .id_pc_o(id_pc_o), .ex_pc_o(ex_pc_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic model_state_t model_reset(model_state_t s);
        model_state_t n;
        n = s;
        n.pc = pipe_pkg::INT_VECTOR;
        n.id_pc = '0;
        n.ex = '0;
        n.intercepted = 1'b1;
        for (int i = 0; i < pipe_pkg::BHT_ENTRIES; i++) begin
            n.ctr[i] = pipe_pkg::CTR_INIT;
        end
        // Exception PC survives reset
        return n;
    endfunction

    // Valid ID branch whose counter reads 2 or 3
    function automatic logic id_predicts_taken(model_state_t s, pipe_pkg::id_info_t info);
        return info.valid && info.isbranch && s.ctr[s.id_pc[pipe_pkg::BHT_BITS-1:0]][1];
    endfunction

    function automatic pipe_pkg::ctrl_t model_ctrl(model_state_t s, pipe_pkg::id_info_t info,
                                                   pipe_pkg::ex_result_t res);
        pipe_pkg::ctrl_t c;
        logic            load_use;
        logic            judge;
        c = '0;
        load_use = s.ex.info.valid && s.ex.info.memread && s.ex.info.memtoreg &&
                   (s.ex.info.regdst == info.regsrc1 || s.ex.info.regdst == info.regsrc2);
        c.isintzero = s.intercepted;
        c.stall     = load_use && !s.intercepted;
        // Resolution in EX only without stall or interception
        judge       = s.ex.info.valid && !c.stall && !s.intercepted;
        c.prewrong  = judge && s.ex.info.isbranch && (s.ex.pred != res.ifbranch);
        c.precorrc  = judge && s.ex.info.isbranch && (s.ex.pred == res.ifbranch);
        c.jr        = judge && s.ex.info.isjump;
        c.flush_if  = c.prewrong || c.jr ||
                      (id_predicts_taken(s, info) && !c.stall && !s.intercepted);
        c.flush_id  = s.intercepted || c.prewrong || c.jr || c.stall;
        c.flush_ex  = s.intercepted;
        return c;
    endfunction

    function automatic model_state_t model_step(model_state_t s, pipe_pkg::id_info_t info,
                                                pipe_pkg::ex_result_t res, logic intc);
        model_state_t                  n;
        pipe_pkg::ctrl_t               c;
        logic [pipe_pkg::BHT_BITS-1:0] idx;
        if (intc) begin
            return model_reset(s);
        end
        c = model_ctrl(s, info, res);
        n = s;
        n.intercepted = 1'b0;
        // Next fetch address with the highest priority first
        if (c.isintzero) begin
            n.pc = pipe_pkg::INT_VECTOR;
        end else if (c.stall) begin
            n.pc = s.pc;
        end else if (c.prewrong) begin
            n.pc = res.ifbranch ? s.ex.info.target : s.ex.pc + 16'd1;
        end else if (c.jr) begin
            n.pc = res.jr_target;
        end else if (id_predicts_taken(s, info)) begin
            n.pc = info.target;
        end else begin
            n.pc = s.pc + 16'd1;
        end
        // IF/ID holds on stall
        if (c.flush_if) begin
            n.id_pc = '0;
        end else if (!c.stall) begin
            n.id_pc = s.pc;
        end
        // ID/EX takes a bubble on any flush
        if (c.flush_id) begin
            n.ex = '0;
        end else begin
            n.ex.info = info;
            n.ex.pc   = s.id_pc;
            n.ex.pred = s.ctr[s.id_pc[pipe_pkg::BHT_BITS-1:0]][1];
        end
        // Counter training by EX branches
        idx = s.ex.pc[pipe_pkg::BHT_BITS-1:0];
        if (s.ex.info.valid && s.ex.info.isbranch && !s.intercepted) begin
            if (res.ifbranch && s.ctr[idx] != 2'd3) begin
                n.ctr[idx] = s.ctr[idx] + 2'd1;
            end else if (!res.ifbranch && s.ctr[idx] != 2'd0) begin
                n.ctr[idx] = s.ctr[idx] - 2'd1;
            end
        end
        if (s.ex.info.valid && !s.intercepted) begin
            n.epc       = s.ex.pc;
            n.epc_known = 1'b1;
        end
        return n;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic int unsigned pick_below(int unsigned range);
        return {$random(seed)} % range;
    endfunction

    // Random program with a small register range so loads collide often
    task automatic fill_program(input int load_pct, input int branch_pct,
                                input int jump_pct, input logic loop_mode);
        pipe_pkg::id_info_t   ins;
        pipe_pkg::ex_result_t res;
        int                   kind;
        for (int a = 0; a < 256; a++) begin
            kind = pick_below(100);
            ins = '0;
            ins.valid    = pick_below(16) != 0;
            ins.regsrc1  = 4'(pick_below(4));
            ins.regsrc2  = 4'(pick_below(4));
            ins.regdst   = 4'(pick_below(4));
            ins.memread  = kind < load_pct;
            ins.memtoreg = kind < load_pct;
            ins.isbranch = kind >= load_pct && kind < load_pct + branch_pct;
            ins.isjump   = kind >= load_pct + branch_pct &&
                           kind < load_pct + branch_pct + jump_pct;
            // Loop mode keeps targets in a 16 word window
            ins.target   = pipe_pkg::INT_VECTOR + 16'(pick_below(loop_mode ? 16 : 256));
            res.ifbranch  = loop_mode ? 1'b1 : pick_below(4) != 0;
            res.spare     = pick_below(2) != 0;
            res.jr_target = pipe_pkg::INT_VECTOR + 16'(pick_below(loop_mode ? 16 : 256));
            prog[a]    = ins;
            outcome[a] = res;
        end
    endtask

    // One model step per edge before driving what the decoder and EX would see
    task automatic run_cycles(input string name, input int n, input logic intc);
        test_name = name;
        repeat (n) begin
            @(posedge CLK);
            state = model_step(state, id_info_i, ex_result_i, interception_i);
            if (intc) begin
                state = model_reset(state);
            end
            interception_i <= intc;
            // A cleared IF/ID slot holds no instruction and decodes as a bubble
            if (state.id_pc == '0) begin
                id_info_i <= '0;
            end else begin
                id_info_i <= prog[state.id_pc[7:0]];
            end
            ex_result_i    <= outcome[state.ex.pc[7:0]];
        end
    endtask

    task automatic check_value(input string sig, input logic [15:0] exp, input logic [15:0] act);
        assert (act === exp) else begin
            $display("MISMATCH test=%s %s expected=%h actual=%h", test_name, sig, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare process samples at the falling edge where outputs are stable
    //////////////////////////////////////////////////////////////////////

    always @(negedge CLK) begin
        pipe_pkg::ctrl_t exp;
        exp = model_ctrl(state, id_info_i, ex_result_i);
        check_value("pc_o", state.pc, pc_o);
        check_value("id_pc_o", state.id_pc, id_pc_o);
        check_value("ex_pc_o", state.ex.pc, ex_pc_o);
        check_value("ctrl_o", {8'h00, exp}, {8'h00, ctrl_o});
        if (state.epc_known) begin
            check_value("epc_o", state.epc, epc_o);
        end
        n_stall    += exp.stall;
        n_prewrong += exp.prewrong;
        n_precorrc += exp.precorrc;
        n_jr       += exp.jr;
        n_redirect += exp.flush_if && !exp.prewrong && !exp.jr;
        // About 800 cycles of tests in total
        cycle_count++;
        if (cycle_count >= 1200) begin
            $display("Timeout after %0d cycles, the test sequence never finished", cycle_count);
            $display("Test failed");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        interception_i <= 1'b1;
        id_info_i      <= '0;
        ex_result_i    <= '0;
        state = model_reset('0);
        fill_program(20, 20, 10, 1'b0);
        // 16 edges with reset high
        run_cycles("reset", 15, 1'b1);
        run_cycles("reset", 1, 1'b0);
        // Intercepted cycle followed by a quiet control word
        @(negedge CLK);
        check_value("pc_o after reset", pipe_pkg::INT_VECTOR, pc_o);
        check_value("ctrl_o after reset", 16'h0031, {8'h00, ctrl_o});
        run_cycles("reset", 1, 1'b0);
        @(negedge CLK);
        check_value("ctrl_o after intercepted cycle", 16'h0000, {8'h00, ctrl_o});
        fill_program(40, 10, 5, 1'b0);
        run_cycles("load_use", 200, 1'b0);
        fill_program(5, 45, 5, 1'b0);
        run_cycles("branch", 200, 1'b0);
        fill_program(20, 10, 30, 1'b0);
        run_cycles("jr", 150, 1'b0);
        // Always taken branches in a short loop
        fill_program(10, 50, 0, 1'b1);
        run_cycles("saturate", 150, 1'b0);
        fill_program(20, 20, 10, 1'b0);
        run_cycles("interception", 40, 1'b0);
        run_cycles("interception", 2, 1'b1);
        run_cycles("interception", 40, 1'b0);
        @(negedge CLK);
        assert (n_stall > 0 && n_prewrong > 0 && n_precorrc > 0 && n_jr > 0 && n_redirect > 0)
        begin
            $display("Test passed");
            $finish;
        end else begin
            $display("A hazard case never occurred: stall=%0d prewrong=%0d precorrc=%0d",
                     n_stall, n_prewrong, n_precorrc);
            $display("jr=%0d redirect=%0d", n_jr, n_redirect);
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
pipe_pkg.sv
pipe_reg.sv
hazard_unit.sv
branch_predictor.sv
pc_unit.sv
pipe_frontend_top.sv
tb_pipe_frontend.sv
